// ==== src/local_mem_pkg.sv ====
// shared constants and types for the local memory subsystem
// ram is 4 KB of 32-bit words, word addressed through word_idx
// peripherals sit in the 0x1000 to 0x1FFF window, everything above is unmapped
// all addresses are byte addresses; peripherals expect word aligned accesses
package local_mem_pkg;

    // ram geometry
    localparam int MEM_WORDS  = 1024;
    localparam int MEM_ADDR_W = 10;

    // stall cycles of a peripheral access after decode
    localparam int PERIPH_LATENCY = 5;
    localparam int PERIPH_CNT_W   = $clog2(PERIPH_LATENCY + 1);

    // address map
    localparam logic [31:0] BRAM_LIMIT   = 32'(MEM_WORDS * 4);
    localparam logic [31:0] PERIPH_LIMIT = 32'h0000_2000;
    localparam logic [31:0] UART_ADDR    = 32'h0000_1000;
    localparam logic [31:0] SCRATCH_ADDR = 32'h0000_1004;
    // read back from any other peripheral address
    localparam logic [31:0] STATUS_WORD  = 32'hFFFF_FF21;

    typedef enum logic [2:0] {
        REG_BRAM,
        REG_UART,
        REG_SCRATCH,
        REG_STATUS,
        REG_NONE
    } region_t;

    // data port request, en is a one cycle pulse
    typedef struct packed {
        logic        en;
        logic        rnw;
        logic [3:0]  be;
        logic [31:0] addr;
        logic [31:0] wdata;
    } data_req_t;

    // fetch port, read only
    typedef struct packed {
        logic        en;
        logic [31:0] addr;
    } inst_req_t;

    // request after the decode stage
    typedef struct packed {
        region_t     region;
        logic        rnw;
        logic [3:0]  be;
        logic [31:0] word_idx;
        logic [31:0] wdata;
    } dec_req_t;

    typedef struct packed {
        logic        valid;
        logic        err;
        logic [31:0] rdata;
    } data_rsp_t;

    typedef struct packed {
        logic       strobe;
        logic [7:0] byte_val;
    } uart_out_t;

endpackage

// ==== src/mem_addr_decode.sv ====
// decode stage of the data port
// one request per cycle, decoded request shows up one cycle after the en pulse
// the requester must hold off while busy is high, there is no other back-pressure
// only the word index is kept, byte lanes are selected by be alone
`timescale 1ns/100ps

module mem_addr_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  local_mem_pkg::data_req_t data_req,
    input  logic                     busy,
    output local_mem_pkg::dec_req_t  dec_req,
    output logic                     dec_valid
);
    import local_mem_pkg::*;

    region_t region;

    // region map, first match wins
    always_comb begin
        if (data_req.addr < BRAM_LIMIT) begin
            region = REG_BRAM;
        end else if (data_req.addr == UART_ADDR) begin
            region = REG_UART;
        end else if (data_req.addr == SCRATCH_ADDR) begin
            region = REG_SCRATCH;
        end else if (data_req.addr < PERIPH_LIMIT) begin
            // rest of the peripheral window reads as status
            region = REG_STATUS;
        end else begin
            region = REG_NONE;
        end
    end

    // valid flag
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= data_req.en;
        end
    end

    // decoded payload, only loaded on a request
    always_ff @(posedge clk) begin
        if (data_req.en) begin
            dec_req.region   <= region;
            dec_req.rnw      <= data_req.rnw;
            dec_req.be       <= data_req.be;
            dec_req.word_idx <= data_req.addr >> 2;
            dec_req.wdata    <= data_req.wdata;
        end
    end

    // busy comes back from the responder, a request during a stall is lost
    a_no_req_while_busy: assert property (
        @(posedge clk) disable iff (rst)
        data_req.en |-> !busy
    ) else $error("data request issued while busy");

    // a write with no byte lanes would be answered but change nothing
    a_write_has_be: assert property (
        @(posedge clk) disable iff (rst)
        (data_req.en && !data_req.rnw) |-> (data_req.be != 4'b0000)
    ) else $error("data write with empty byte enables");

endmodule

// ==== src/byte_en_bram.sv ====
// true dual-port ram, 32-bit words
// port a is the fetch port, read only, data one cycle after inst_en
// port b takes decoded data requests of the ram region, writes per byte lane
// a same-cycle write on b and read on a of one word gives a the old word
// contents are not cleared by reset, inst_valid follows inst_en after one clock
`timescale 1ns/100ps

module byte_en_bram (
    input  logic                                clk,
    input  logic [local_mem_pkg::MEM_ADDR_W-1:0] inst_addr,
    input  logic                                inst_en,
    output logic [31:0]                         inst_rdata,
    output logic                                inst_valid,
    input  local_mem_pkg::dec_req_t             dec_req,
    input  logic                                dec_valid,
    output logic [31:0]                         bram_rdata
);
    import local_mem_pkg::*;

    logic [31:0]           mem [MEM_WORDS];
    logic                  b_en;
    logic                  b_we;
    logic [MEM_ADDR_W-1:0] b_addr;

    // port b only reacts to ram hits
    assign b_en   = dec_valid && (dec_req.region == REG_BRAM);
    assign b_we   = b_en && !dec_req.rnw;
    // ram region is below BRAM_LIMIT so the upper index bits are zero
    assign b_addr = dec_req.word_idx[MEM_ADDR_W-1:0];

    // port a, registered fetch read
    always_ff @(posedge clk) begin
        inst_valid <= inst_en;
        if (inst_en) begin
            inst_rdata <= mem[inst_addr];
        end
    end

    // port b write, per byte lane
    always_ff @(posedge clk) begin
        if (b_we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dec_req.be[lane]) begin
                    mem[b_addr][8*lane +: 8] <= dec_req.wdata[8*lane +: 8];
                end
            end
        end
    end

    // port b read, old data on a write
    // result stage zeroes rdata for writes anyway
    always_ff @(posedge clk) begin
        if (b_en) begin
            bram_rdata <= mem[b_addr];
        end
    end

endmodule

// ==== src/periph_responder.sv ====
// execute stage for the uart, scratch and status targets
// fixed stall: busy from the decode cycle for PERIPH_LATENCY + 1 cycles,
// periph_done in the cycle busy drops
// only one peripheral access is in flight, the requester waits on busy
// uart reads return 0, status reads return STATUS_WORD
// write responses carry rdata of 0
`timescale 1ns/100ps

module periph_responder (
    input  logic                    clk,
    input  logic                    rst,
    input  local_mem_pkg::dec_req_t dec_req,
    input  logic                    dec_valid,
    output logic                    busy,
    output logic                    periph_done,
    output logic [31:0]             periph_rdata,
    output logic                    periph_uart_wr
);
    import local_mem_pkg::*;

    logic                    is_periph;
    logic                    start;
    logic                    scratch_wr;
    logic [PERIPH_CNT_W-1:0] cnt;
    logic [31:0]             scratch_q;
    logic [31:0]             rdata_q;
    logic                    uart_wr_q;

    assign is_periph  = (dec_req.region == REG_UART)    ||
                        (dec_req.region == REG_SCRATCH) ||
                        (dec_req.region == REG_STATUS);
    assign start      = dec_valid && is_periph;
    assign scratch_wr = start && (dec_req.region == REG_SCRATCH) && !dec_req.rnw;

    // busy covers the decode cycle too, the counter takes over after it
    assign busy = start || (cnt != '0);

    // stall counter and done pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt         <= '0;
            periph_done <= 1'b0;
            uart_wr_q   <= 1'b0;
        end else begin
            // last counted cycle, response goes out next
            periph_done <= (cnt == PERIPH_CNT_W'(1));
            if (start) begin
                cnt       <= PERIPH_CNT_W'(PERIPH_LATENCY);
                uart_wr_q <= (dec_req.region == REG_UART) && !dec_req.rnw;
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // scratch register, byte lane writes
    always_ff @(posedge clk) begin
        if (rst) begin
            scratch_q <= '0;
        end else if (scratch_wr) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (dec_req.be[lane]) begin
                    scratch_q[8*lane +: 8] <= dec_req.wdata[8*lane +: 8];
                end
            end
        end
    end

    // read data captured at the start and held through the stall
    always_ff @(posedge clk) begin
        if (start) begin
            if (!dec_req.rnw) begin
                rdata_q <= '0;
            end else begin
                case (dec_req.region)
                    REG_SCRATCH: rdata_q <= scratch_q;
                    REG_STATUS:  rdata_q <= STATUS_WORD;
                    default:     rdata_q <= '0;
                endcase
            end
        end
    end

    assign periph_rdata   = rdata_q;
    // stays set until the next access, qualified by periph_done downstream
    assign periph_uart_wr = uart_wr_q;

    // every access answers after exactly the fixed stall
    a_fixed_latency: assert property (
        @(posedge clk) disable iff (rst)
        start |-> ##(PERIPH_LATENCY + 1) periph_done
    ) else $error("peripheral response latency wrong");

endmodule

// ==== src/mem_result.sv ====
// result stage of the data port
// ram and unmapped responses come out two cycles after the request pulse,
// peripheral responses when periph_done pulses
// the two never meet as long as nothing is issued while busy
// uart strobe shares the cycle of its write response
`timescale 1ns/100ps

module mem_result (
    input  logic                     clk,
    input  logic                     rst,
    input  local_mem_pkg::dec_req_t  dec_req,
    input  logic                     dec_valid,
    input  logic [31:0]              bram_rdata,
    input  logic                     periph_done,
    input  logic [31:0]              periph_rdata,
    input  logic                     periph_uart_wr,
    output local_mem_pkg::data_rsp_t data_rsp,
    output local_mem_pkg::uart_out_t uart
);
    import local_mem_pkg::*;

    logic       pend_valid;
    region_t    pend_region;
    logic       pend_rnw;
    logic [7:0] uart_byte_q;

    // ram and unmapped requests line up with the ram read data
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= dec_valid &&
                          ((dec_req.region == REG_BRAM) || (dec_req.region == REG_NONE));
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            pend_region <= dec_req.region;
            pend_rnw    <= dec_req.rnw;
        end
    end

    // uart byte waits here for the stall to finish
    always_ff @(posedge clk) begin
        if (dec_valid && (dec_req.region == REG_UART) && !dec_req.rnw) begin
            uart_byte_q <= dec_req.wdata[7:0];
        end
    end

    // response select
    always_comb begin
        data_rsp = '0;
        if (pend_valid) begin
            data_rsp.valid = 1'b1;
            if (pend_region == REG_NONE) begin
                // unmapped, error with zero data
                data_rsp.err = 1'b1;
            end else if (pend_rnw) begin
                data_rsp.rdata = bram_rdata;
            end
        end else if (periph_done) begin
            data_rsp.valid = 1'b1;
            data_rsp.rdata = periph_rdata;
        end
    end

    assign uart.strobe   = periph_done && periph_uart_wr;
    assign uart.byte_val = uart_byte_q;

    // ram path and peripheral path would fight for the one response slot
    a_no_rsp_collision: assert property (
        @(posedge clk) disable iff (rst)
        !(pend_valid && periph_done)
    ) else $error("ram and peripheral responses in the same cycle");

endmodule

// ==== src/local_mem_top.sv ====
// local memory subsystem top, decode, execute and result stages
// fetch port is never stalled and answers one cycle after inst_req.en
// data port answers two cycles later for ram and unmapped addresses,
// PERIPH_LATENCY + 2 cycles later for peripherals
// fetch addresses wrap inside the 4 KB ram
`timescale 1ns/100ps

module local_mem_top (
    input  logic                     clk,
    input  logic                     rst,
    input  local_mem_pkg::inst_req_t inst_req,
    input  local_mem_pkg::data_req_t data_req,
    output logic [31:0]              inst_rdata,
    output logic                     inst_valid,
    output local_mem_pkg::data_rsp_t data_rsp,
    output logic                     busy,
    output local_mem_pkg::uart_out_t uart
);
    import local_mem_pkg::*;

    dec_req_t    dec_req;
    logic        dec_valid;
    logic [31:0] bram_rdata;
    logic        periph_done;
    logic [31:0] periph_rdata;
    logic        periph_uart_wr;

    // decode
    mem_addr_decode decode_i (
        .clk       (clk),
        .rst       (rst),
        .data_req  (data_req),
        .busy      (busy),
        .dec_req   (dec_req),
        .dec_valid (dec_valid)
    );

    // execute, ram shared by fetch and data
    byte_en_bram bram_i (
        .clk        (clk),
        .inst_addr  (inst_req.addr[MEM_ADDR_W+1:2]),
        .inst_en    (inst_req.en),
        .inst_rdata (inst_rdata),
        .inst_valid (inst_valid),
        .dec_req    (dec_req),
        .dec_valid  (dec_valid),
        .bram_rdata (bram_rdata)
    );

    // execute, peripherals
    periph_responder periph_i (
        .clk            (clk),
        .rst            (rst),
        .dec_req        (dec_req),
        .dec_valid      (dec_valid),
        .busy           (busy),
        .periph_done    (periph_done),
        .periph_rdata   (periph_rdata),
        .periph_uart_wr (periph_uart_wr)
    );

    // result
    mem_result result_i (
        .clk            (clk),
        .rst            (rst),
        .dec_req        (dec_req),
        .dec_valid      (dec_valid),
        .bram_rdata     (bram_rdata),
        .periph_done    (periph_done),
        .periph_rdata   (periph_rdata),
        .periph_uart_wr (periph_uart_wr),
        .data_rsp       (data_rsp),
        .uart           (uart)
    );

endmodule

// ==== test/local_mem_tb_table.svh ====
// stimulus table of the directed tests, applied in order
// columns: name, fetch, rnw, be, byte address, wdata, expected err,
// expected rdata or fetch word, expected uart byte or NO_UART
// rows depend on the ones before them, the ram is written before it is read
// fetch rows ignore rnw, be and wdata

task automatic build_table();
    // ram word write, partial merge, then data and fetch readback
    add_row("ram_full_wr",    0, 0, 4'hF, 32'h10,   32'h11223344, 0, 32'h0, NO_UART);
    add_row("ram_part_wr",    0, 0, 4'h5, 32'h10,   32'hAABBCCDD, 0, 32'h0, NO_UART);
    add_row("ram_merged_rd",  0, 1, 4'hF, 32'h10,   32'h0, 0, 32'h11BB33DD, NO_UART);
    add_row("fetch_merged",   1, 1, 4'hF, 32'h10,   32'h0, 0, 32'h11BB33DD, NO_UART);
    // top word of the ram
    add_row("ram_top_wr",     0, 0, 4'hF, 32'hFFC,  32'hCAFEF00D, 0, 32'h0, NO_UART);
    add_row("ram_top_rd",     0, 1, 4'hF, 32'hFFC,  32'h0, 0, 32'hCAFEF00D, NO_UART);
    add_row("fetch_top",      1, 1, 4'hF, 32'hFFC,  32'h0, 0, 32'hCAFEF00D, NO_UART);
    // uart capture, only the low byte goes out
    add_row("uart_wr",        0, 0, 4'h1, 32'h1000, 32'h00000041, 0, 32'h0, 32'h41);
    add_row("uart_wr_hi_set", 0, 0, 4'h1, 32'h1000, 32'h123456C3, 0, 32'h0, 32'hC3);
    // scratch from reset, then two lane merges
    add_row("scratch_rst_rd", 0, 1, 4'hF, 32'h1004, 32'h0, 0, 32'h0, NO_UART);
    add_row("scratch_wr_lo",  0, 0, 4'h3, 32'h1004, 32'hDEADBEEF, 0, 32'h0, NO_UART);
    add_row("scratch_wr_hi",  0, 0, 4'h8, 32'h1004, 32'h5A000000, 0, 32'h0, NO_UART);
    add_row("scratch_rd",     0, 1, 4'hF, 32'h1004, 32'h0, 0, 32'h5A00BEEF, NO_UART);
    // rest of the peripheral window
    add_row("status_rd",      0, 1, 4'hF, 32'h1010, 32'h0, 0, STATUS_WORD, NO_UART);
    add_row("status_rd_top",  0, 1, 4'hF, 32'h1FFC, 32'h0, 0, STATUS_WORD, NO_UART);
    // unmapped, error at the ram latency and no stall
    add_row("unmapped_rd",    0, 1, 4'hF, 32'h4000, 32'h0, 1, 32'h0, NO_UART);
    add_row("unmapped_wr",    0, 0, 4'hF, 32'h2000, 32'h12345678, 1, 32'h0, NO_UART);
endtask

// ==== test/local_mem_tb.sv ====
// testbench for the local memory subsystem, the stimulus plays the core
// one access at a time, checked cycle by cycle against the fixed latencies
// inputs change on the rising edge, outputs are sampled on the falling edge
// back-to-back ram reads and a random ram fill run after the table
`timescale 1ns/100ps

module local_mem_tb;
    import local_mem_pkg::*;

    localparam int NO_UART = -1;

    typedef struct {
        string       name;
        bit          fetch;
        data_req_t   req;
        bit          exp_err;
        logic [31:0] exp_data;
        int          exp_uart;
    } row_t;

    logic        clk = 1'b0;
    logic        rst;
    inst_req_t   inst_req;
    data_req_t   data_req;
    logic [31:0] inst_rdata;
    logic        inst_valid;
    data_rsp_t   data_rsp;
    logic        busy;
    uart_out_t   uart;

    row_t        rows[$];
    // expected ram contents for the random fill
    logic [31:0] model [MEM_WORDS];
    int          seed = 32'h73493cb8;
    int          n_pass = 0;
    int          n_fail = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    local_mem_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .inst_req   (inst_req),
        .data_req   (data_req),
        .inst_rdata (inst_rdata),
        .inst_valid (inst_valid),
        .data_rsp   (data_rsp),
        .busy       (busy),
        .uart       (uart)
    );

    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic data_req_t make_req(bit rnw, logic [3:0] be, logic [31:0] addr,
                                           logic [31:0] wdata);
        return '{1'b1, rnw, be, addr, wdata};
    endfunction

    // response cycle after the pulse, from the address map
    function automatic int data_latency(logic [31:0] addr);
        if (addr >= 32'h1000 && addr < 32'h2000) begin
            return PERIPH_LATENCY + 2;
        end
        return 2;
    endfunction

    function automatic bit check_value(string test, string what, logic [31:0] exp,
                                       logic [31:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s %s expected %h actual %h", test, what, exp, act);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic add_row(input string name, input bit fetch, input bit rnw,
                           input logic [3:0] be, input logic [31:0] addr,
                           input logic [31:0] wdata, input bit exp_err,
                           input logic [31:0] exp_data, input int exp_uart);
        row_t r;
        r.name     = name;
        r.fetch    = fetch;
        r.req      = make_req(rnw, be, addr, wdata);
        r.exp_err  = exp_err;
        r.exp_data = exp_data;
        r.exp_uart = exp_uart;
        rows.push_back(r);
    endtask

    `include "local_mem_tb_table.svh"

    // one pulse, then every cycle up to the response is checked
    task automatic run_access(input string name, input bit fetch, input data_req_t req,
                              input bit exp_err, input logic [31:0] exp_data,
                              input int exp_uart, output bit ok);
        int  lat;
        bit  last;
        ok  = 1'b1;
        lat = fetch ? 1 : data_latency(req.addr);
        @(posedge clk);
        if (fetch) begin
            inst_req <= '{1'b1, req.addr};
        end else begin
            data_req <= req;
        end
        @(posedge clk);
        inst_req <= '0;
        data_req <= '0;
        for (int k = 1; k <= lat; k++) begin
            if (k > 1) begin
                @(posedge clk);
            end
            @(negedge clk);
            last = (k == lat);
            ok &= check_value(name, $sformatf("inst_valid at N+%0d", k),
                              32'(fetch && last), 32'(inst_valid));
            ok &= check_value(name, $sformatf("data_rsp.valid at N+%0d", k),
                              32'(!fetch && last), 32'(data_rsp.valid));
            // peripherals stall from N+1 until the response cycle
            ok &= check_value(name, $sformatf("busy at N+%0d", k),
                              32'(!fetch && lat > 2 && !last), 32'(busy));
            ok &= check_value(name, $sformatf("uart strobe at N+%0d", k),
                              32'(last && exp_uart >= 0), 32'(uart.strobe));
            if (last && fetch) begin
                ok &= check_value(name, "inst_rdata", exp_data, inst_rdata);
            end
            if (last && !fetch) begin
                ok &= check_value(name, "err", 32'(exp_err), 32'(data_rsp.err));
                ok &= check_value(name, "rdata", exp_data, data_rsp.rdata);
            end
            if (last && exp_uart >= 0) begin
                ok &= check_value(name, "uart byte", 32'(exp_uart), 32'(uart.byte_val));
            end
        end
    endtask

    // three reads on consecutive cycles, answers two cycles after each
    task automatic run_back_to_back(output bit ok);
        bit acc_ok;
        ok = 1'b1;
        for (int k = 0; k < 3; k++) begin
            run_access("b2b_fill", 0, make_req(0, 4'hF, 32'h200 + 32'(4 * k),
                       32'hB2B00000 + 32'(k)), 0, 32'h0, NO_UART, acc_ok);
            ok &= acc_ok;
        end
        for (int k = 0; k < 5; k++) begin
            @(posedge clk);
            if (k < 3) begin
                data_req <= make_req(1, 4'hF, 32'h200 + 32'(4 * k), 32'h0);
            end else begin
                data_req <= '0;
            end
            if (k >= 2) begin
                @(negedge clk);
                if (data_rsp.valid !== 1'b1) begin
                    $display("b2b: no response for read %0d", k - 2);
                    ok = 1'b0;
                end
                ok &= check_value("b2b", "rdata", 32'hB2B00000 + 32'(k - 2), data_rsp.rdata);
            end
        end
        @(posedge clk);
        @(negedge clk);
        if (data_rsp.valid !== 1'b0) begin
            $display("b2b: extra response after the last read");
            ok = 1'b0;
        end
    endtask

    // random words at random word addresses, last write wins in the model
    task automatic run_random_fill(output bit ok);
        logic [31:0] addrs [64];
        logic [31:0] word;
        bit          acc_ok;
        ok = 1'b1;
        for (int k = 0; k < 64; k++) begin
            addrs[k] = 32'(($random(seed) & (MEM_WORDS - 1)) << 2);
            word     = $random(seed);
            model[addrs[k][MEM_ADDR_W+1:2]] = word;
            run_access("rand_wr", 0, make_req(0, 4'hF, addrs[k], word), 0, 32'h0,
                       NO_UART, acc_ok);
            ok &= acc_ok;
        end
        for (int k = 0; k < 64; k++) begin
            run_access("rand_rd", 0, make_req(1, 4'hF, addrs[k], 32'h0), 0,
                       model[addrs[k][MEM_ADDR_W+1:2]], NO_UART, acc_ok);
            ok &= acc_ok;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            n_pass++;
            $display("test %s ok", name);
        end else begin
            n_fail++;
            $display("test %s failed", name);
        end
    endtask

    initial begin
        bit ok;
        rst      = 1'b1;
        inst_req = '0;
        data_req = '0;
        build_table();
        // every access takes at most PERIPH_LATENCY + 3 cycles
        cycle_limit = (rows.size() + 2 * 64 + 8) * (PERIPH_LATENCY + 4) + 50;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        ok = (data_rsp.valid === 1'b0) && (inst_valid === 1'b0) &&
             (busy === 1'b0) && (uart.strobe === 1'b0);
        if (!ok) begin
            $display("outputs not idle after reset");
        end
        report_test("reset_idle", ok);
        foreach (rows[i]) begin
            run_access(rows[i].name, rows[i].fetch, rows[i].req, rows[i].exp_err,
                       rows[i].exp_data, rows[i].exp_uart, ok);
            report_test(rows[i].name, ok);
        end
        run_back_to_back(ok);
        report_test("ram_back_to_back", ok);
        run_random_fill(ok);
        report_test("ram_random_fill", ok);
        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+test
src/local_mem_pkg.sv
src/mem_addr_decode.sv
src/byte_en_bram.sv
src/periph_responder.sv
src/mem_result.sv
src/local_mem_top.sv
test/local_mem_tb.sv

// ==== Makefile ====
# verilator simulation of the local memory subsystem

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal -f all.f --top-module local_mem_tb -Mdir obj_dir
	./obj_dir/Vlocal_mem_tb | tee /dev/stderr | grep -qF "*** TEST PASSED ***"

clean:
	rm -rf obj_dir
